//--- common/arcade_pkg.sv
////////////////////
// Arcade front end shared types
// PS/2 events, key map, player controls, menu options,
// AXI4-Lite channel structs and register offsets
////////////////////

package arcade_pkg;

  // One PS/2 report from the HPS side
  // Toggle flips once per new event
  typedef struct packed {
    logic       toggle;
    logic       pressed;
    logic       extended;
    logic [7:0] code;
  } ps2_event_t;

  // Held state of every mapped key
  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
    logic ctrl;
    logic alt;
    logic space;
    logic shift;
    logic num_1;
    logic num_2;
    logic num_5;
    logic num_6;
    logic a;
    logic s;
    logic q;
    logic r;
    logic f;
    logic d;
    logic g;
    logic p;
    logic w;
  } key_state_t;

  // Controls for one player
  // Buttons are 4 down to 1
  typedef struct packed {
    logic       up;
    logic       down;
    logic       left;
    logic       right;
    logic [3:0] buttons;
    logic       start;
    logic       coin;
    logic       pause;
  } player_t;

  // Menu options as seen by the core
  typedef struct packed {
    logic [3:0] offset_x;
    logic [3:0] offset_y;
    logic       rotate;
    logic       flip;
    logic       compatibility;
    logic       service;
    logic       sprite_en;
    logic [2:0] layer_en;
    logic [3:0] game_index;
    logic [2:0] scandoubler_fx;
  } game_options_t;

  ////////////////////
  // AXI4-Lite
  ////////////////////

  // Master to slave
  typedef struct packed {
    logic        awvalid;
    logic [3:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [3:0]  araddr;
    logic        rready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  // Register byte offsets
  localparam logic [3:0] REG_STATUS  = 4'h0;
  localparam logic [3:0] REG_PLAYERS = 4'h4;
  localparam logic [3:0] REG_ASPECT  = 4'h8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- logic/reset_ctrl.sv
////////////////////
// Reset stretcher
// Asserts with its input, releases synchronously
// a fixed number of cycles later
////////////////////

`timescale 1ns/1ps

module reset_ctrl #(
  parameter int RESET_STRETCH = 16
) (
  input  logic clk_sys,
  input  logic rst_in,
  output logic rst_out
);

  localparam int CW = $clog2(RESET_STRETCH + 1);

  // Cycles left before release
  logic [CW-1:0] count;

  // Input acts as the async reset here
  // Output rises at once, counter reloads on every assertion
  always_ff @(posedge clk_sys or posedge rst_in) begin
    if (rst_in) begin
      count   <= CW'(RESET_STRETCH - 1);
      rst_out <= 1'b1;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end else begin
      // Count expired, release on this edge
      rst_out <= 1'b0;
    end
  end

endmodule

//--- logic/lock_monitor.sv
////////////////////
// PLL lock monitor
// Pulses the PLL reset for LOCK_HOLD cycles
// when lock is lost
////////////////////

`timescale 1ns/1ps

module lock_monitor #(
  parameter int LOCK_HOLD = 256
) (
  input  logic clk_sys,
  input  logic RESET,
  input  logic pll_locked,
  output logic pll_reset
);

  localparam int CW = $clog2(LOCK_HOLD + 1);

  logic          locked_q;
  logic [CW-1:0] hold_cnt;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      locked_q  <= 1'b0;
      hold_cnt  <= '0;
      pll_reset <= 1'b0;
    end else begin
      locked_q <= pll_locked;
      // Falling lock starts the hold
      // A second loss during the hold is part of the same reset
      if (!pll_reset && locked_q && !pll_locked) begin
        hold_cnt  <= CW'(LOCK_HOLD - 1);
        pll_reset <= 1'b1;
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end else begin
        pll_reset <= 1'b0;
      end
    end
  end

  // Hold length is bounded
  a_hold_len : assert property (
    @(posedge clk_sys) disable iff (RESET)
    $rose(pll_reset) |-> ##LOCK_HOLD !pll_reset
  );

endmodule

//--- input/key_decoder.sv
////////////////////
// Input stage 1
// Tracks PS/2 key state and registers the joysticks
////////////////////

`timescale 1ns/1ps

module key_decoder
  import arcade_pkg::*;
(
  input  logic        clk_sys,
  input  logic        RESET,
  input  ps2_event_t  ps2,
  input  logic [31:0] joystick_0,
  input  logic [31:0] joystick_1,
  output key_state_t  keys,
  output logic [10:0] joy_0_q,
  output logic [10:0] joy_1_q
);

  logic       toggle_q;
  logic       new_event;
  key_state_t keys_d;

  // Any flip of the toggle bit is a fresh report
  assign new_event = ps2.toggle != toggle_q;

  // Scan code map
  always_comb begin
    keys_d = keys;
    if (new_event) begin
      case (ps2.code)
        8'h75: keys_d.up    = ps2.pressed;
        8'h72: keys_d.down  = ps2.pressed;
        8'h6B: keys_d.left  = ps2.pressed;
        8'h74: keys_d.right = ps2.pressed;
        8'h14: keys_d.ctrl  = ps2.pressed;
        8'h11: keys_d.alt   = ps2.pressed;
        8'h29: keys_d.space = ps2.pressed;
        8'h12: keys_d.shift = ps2.pressed;
        8'h16: keys_d.num_1 = ps2.pressed;
        8'h1E: keys_d.num_2 = ps2.pressed;
        8'h2E: keys_d.num_5 = ps2.pressed;
        8'h36: keys_d.num_6 = ps2.pressed;
        8'h1C: keys_d.a     = ps2.pressed;
        8'h1B: keys_d.s     = ps2.pressed;
        8'h15: keys_d.q     = ps2.pressed;
        8'h2D: keys_d.r     = ps2.pressed;
        8'h2B: keys_d.f     = ps2.pressed;
        8'h23: keys_d.d     = ps2.pressed;
        8'h34: keys_d.g     = ps2.pressed;
        8'h4D: keys_d.p     = ps2.pressed;
        8'h1D: keys_d.w     = ps2.pressed;
        // Unmapped codes are ignored
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      toggle_q <= 1'b0;
      keys     <= '0;
      joy_0_q  <= '0;
      joy_1_q  <= '0;
    end else begin
      toggle_q <= ps2.toggle;
      keys     <= keys_d;
      // Only the low 11 bits carry controls
      joy_0_q  <= joystick_0[10:0];
      joy_1_q  <= joystick_1[10:0];
    end
  end

  // No toggle change, no key change
  a_keys_quiet : assert property (
    @(posedge clk_sys) disable iff (RESET)
    (ps2.toggle == toggle_q) |=> $stable(keys)
  );

endmodule

//--- input/player_merge.sv
////////////////////
// Input stage 2
// Merges keys with joystick bits into player structs
////////////////////

`timescale 1ns/1ps

module player_merge
  import arcade_pkg::*;
(
  input  logic        clk_sys,
  input  logic        RESET,
  input  key_state_t  keys,
  input  logic [10:0] joy_0_q,
  input  logic [10:0] joy_1_q,
  output player_t     player_0,
  output player_t     player_1
);

  player_t p0_d;
  player_t p1_d;

  // Joystick bits: 0 right, 1 left, 2 down, 3 up,
  // 7..4 buttons, 8 start, 9 coin, 10 pause
  always_comb begin
    p0_d.up      = keys.up    | joy_0_q[3];
    p0_d.down    = keys.down  | joy_0_q[2];
    p0_d.left    = keys.left  | joy_0_q[1];
    p0_d.right   = keys.right | joy_0_q[0];
    p0_d.buttons = {keys.shift, keys.space, keys.alt, keys.ctrl} | joy_0_q[7:4];
    p0_d.start   = keys.num_1 | joy_0_q[8];
    p0_d.coin    = keys.num_5 | joy_0_q[9];
    p0_d.pause   = keys.p     | joy_0_q[10];

    // Second player on the left-hand keys
    p1_d.up      = keys.r     | joy_1_q[3];
    p1_d.down    = keys.f     | joy_1_q[2];
    p1_d.left    = keys.d     | joy_1_q[1];
    p1_d.right   = keys.g     | joy_1_q[0];
    p1_d.buttons = {keys.w, keys.q, keys.s, keys.a} | joy_1_q[7:4];
    p1_d.start   = keys.num_2 | joy_1_q[8];
    p1_d.coin    = keys.num_6 | joy_1_q[9];
    // No pause key for player 1
    p1_d.pause   = joy_1_q[10];
  end

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      player_0 <= '0;
      player_1 <= '0;
    end else begin
      player_0 <= p0_d;
      player_1 <= p1_d;
    end
  end

endmodule

//--- logic/status_regs.sv
////////////////////
// AXI4-Lite status registers
// Holds the menu status word, decodes options and aspect,
// reads back player state
////////////////////

`timescale 1ns/1ps

module status_regs
  import arcade_pkg::*;
(
  input  logic          clk_sys,
  input  logic          RESET,
  input  axil_req_t     axil_req,
  output axil_rsp_t     axil_rsp,
  input  player_t       player_0,
  input  player_t       player_1,
  output logic [31:0]   status,
  output logic          soft_reset,
  output game_options_t options,
  output logic [12:0]   video_arx,
  output logic [12:0]   video_ary
);

  logic        bvalid_q;
  logic [1:0]  bresp_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic [1:0]  rresp_q;
  logic        wr_hs;
  logic        rd_hs;
  logic [1:0]  aspect;
  logic        orientation;

  // Address and data taken together, one response outstanding
  assign wr_hs = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign rd_hs = axil_req.arvalid && !rvalid_q;

  always_comb begin
    axil_rsp.awready = wr_hs;
    axil_rsp.wready  = wr_hs;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = rd_hs;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

  ////////////////////
  // Write channel
  ////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      status   <= '0;
      bvalid_q <= 1'b0;
    end else if (wr_hs) begin
      bvalid_q <= 1'b1;
      if (axil_req.awaddr == REG_STATUS) begin
        // Byte lanes per wstrb
        for (int i = 0; i < 4; i++) begin
          if (axil_req.wstrb[i]) begin
            status[8*i +: 8] <= axil_req.wdata[8*i +: 8];
          end
        end
      end
    end else if (bvalid_q && axil_req.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  // Response code rides with the handshake
  always_ff @(posedge clk_sys) begin
    if (wr_hs) begin
      bresp_q <= (axil_req.awaddr == REG_STATUS) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  ////////////////////
  // Read channel
  ////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      rvalid_q <= 1'b0;
    end else if (rd_hs) begin
      rvalid_q <= 1'b1;
    end else if (rvalid_q && axil_req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // Data captured once, held while rvalid waits
  always_ff @(posedge clk_sys) begin
    if (rd_hs) begin
      rresp_q <= RESP_OKAY;
      case (axil_req.araddr)
        REG_STATUS:  rdata_q <= status;
        REG_PLAYERS: rdata_q <= {10'b0, player_1, player_0};
        REG_ASPECT:  rdata_q <= {3'b0, video_ary, 3'b0, video_arx};
        default: begin
          rdata_q <= '0;
          rresp_q <= RESP_SLVERR;
        end
      endcase
    end
  end

  ////////////////////
  // Status decode
  ////////////////////

  assign soft_reset  = status[0];
  assign aspect      = status[2:1];
  assign orientation = status[3];

  // Zero means original ratio, else one of the custom ARC modes
  assign video_arx = (aspect == 2'd0) ? (orientation ? 13'd3 : 13'd4)
                                      : 13'(aspect) - 13'd1;
  assign video_ary = (aspect == 2'd0) ? (orientation ? 13'd4 : 13'd3) : 13'd0;

  always_comb begin
    options.offset_x       = status[27:24];
    options.offset_y       = status[31:28];
    options.rotate         = status[3];
    options.flip           = status[4];
    options.compatibility  = status[8];
    options.service        = status[9];
    // Menu bits are "off" flags
    options.sprite_en      = ~status[10];
    options.layer_en       = ~status[13:11];
    options.game_index     = status[21:18];
    options.scandoubler_fx = status[7:5];
  end

  a_bvalid_hold : assert property (
    @(posedge clk_sys) disable iff (RESET)
    bvalid_q && !axil_req.bready |=> bvalid_q
  );

  a_rvalid_hold : assert property (
    @(posedge clk_sys) disable iff (RESET)
    rvalid_q && !axil_req.rready |=> rvalid_q && $stable(rdata_q)
  );

endmodule

//--- logic/core_frontend.sv
////////////////////
// Arcade core front end
// Lock monitor, resets, input pipeline and status registers
////////////////////

`timescale 1ns/1ps

module core_frontend
  import arcade_pkg::*;
#(
  parameter int LOCK_HOLD     = 256,
  parameter int RESET_STRETCH = 16
) (
  input  logic          clk_sys,
  input  logic          RESET,
  input  logic          pll_locked,
  input  ps2_event_t    ps2,
  input  logic [31:0]   joystick_0,
  input  logic [31:0]   joystick_1,
  input  axil_req_t     axil_req,
  output logic          pll_reset,
  output logic          rst_sys,
  output logic          rst_core,
  output player_t       player_0,
  output player_t       player_1,
  output game_options_t options,
  output logic [12:0]   video_arx,
  output logic [12:0]   video_ary,
  output axil_rsp_t     axil_rsp
);

  key_state_t  keys;
  logic [10:0] joy_0_q;
  logic [10:0] joy_1_q;
  logic        soft_reset;

  lock_monitor #(.LOCK_HOLD(LOCK_HOLD)) u_lock (
    .clk_sys   (clk_sys),
    .RESET     (RESET),
    .pll_locked(pll_locked),
    .pll_reset (pll_reset)
  );

  // System reset follows board reset and lock
  reset_ctrl #(.RESET_STRETCH(RESET_STRETCH)) u_rst_sys (
    .clk_sys(clk_sys),
    .rst_in (RESET | ~pll_locked),
    .rst_out(rst_sys)
  );

  // Core reset also takes the menu reset bit
  reset_ctrl #(.RESET_STRETCH(RESET_STRETCH)) u_rst_core (
    .clk_sys(clk_sys),
    .rst_in (RESET | ~pll_locked | soft_reset),
    .rst_out(rst_core)
  );

  key_decoder u_keys (
    .clk_sys   (clk_sys),
    .RESET     (RESET),
    .ps2       (ps2),
    .joystick_0(joystick_0),
    .joystick_1(joystick_1),
    .keys      (keys),
    .joy_0_q   (joy_0_q),
    .joy_1_q   (joy_1_q)
  );

  player_merge u_merge (
    .clk_sys (clk_sys),
    .RESET   (RESET),
    .keys    (keys),
    .joy_0_q (joy_0_q),
    .joy_1_q (joy_1_q),
    .player_0(player_0),
    .player_1(player_1)
  );

  // Raw status word stays inside, the core sees decoded options
  status_regs u_regs (
    .clk_sys   (clk_sys),
    .RESET     (RESET),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .player_0  (player_0),
    .player_1  (player_1),
    .status    (),
    .soft_reset(soft_reset),
    .options   (options),
    .video_arx (video_arx),
    .video_ary (video_ary)
  );

endmodule

//--- tests/tb_tasks.svh
////////////////////
// Testbench tasks for the core front end
// Drivers, AXI4-Lite transfers, checks and directed tests
////////////////////

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

////////////////////
// Checks
////////////////////

task automatic abort_run();
  $display("SOME TESTS FAILED");
  $fatal(1, "stopping on first error");
endtask

task automatic check_eq(input string name, input logic [31:0] got,
                        input logic [31:0] want);
  if (got !== want) begin
    $display("CHECK FAILED: %s = 0x%0h, expected 0x%0h", name, got, want);
    abort_run();
  end
endtask

task automatic check_players(input player_t e0, input player_t e1);
  check_eq("player_0", 32'(player_0), 32'(e0));
  check_eq("player_1", 32'(player_1), 32'(e1));
endtask

// Sample point at the negedge after n more rising edges
task automatic settle(input int n);
  repeat (n) @(posedge clk_sys);
  @(negedge clk_sys);
endtask

// Called at a negedge
// Counts cycles from the release edge count
task automatic check_release(input logic core, input int from);
  int n;
  n = 0;
  while (core ? rst_core : rst_sys) begin
    n++;
    if (n > 50) begin
      $display("Reset output never released");
      abort_run();
    end
    @(negedge clk_sys);
  end
  check_eq(core ? "rst_core release cycles" : "rst_sys release cycles",
           32'(cycle - from), 32'(RESET_STRETCH));
endtask

////////////////////
// Drivers
////////////////////

task automatic ps2_event(input logic [7:0] code, input logic pressed,
                         input logic flip);
  // No flip means a repeat of the last report
  if (flip) begin
    tgl = ~tgl;
  end
  @(posedge clk_sys);
  ps2 <= {tgl, pressed, 1'b0, code};
endtask

task automatic drive_joysticks(input logic [31:0] a, input logic [31:0] b);
  @(posedge clk_sys);
  joystick_0 <= a;
  joystick_1 <= b;
endtask

task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input int bdelay,
                         output logic [1:0] resp);
  int n;
  n = 0;
  @(posedge clk_sys);
  axil_req.awvalid <= 1'b1;
  axil_req.wvalid  <= 1'b1;
  axil_req.awaddr  <= addr;
  axil_req.wdata   <= data;
  axil_req.wstrb   <= strb;
  axil_req.bready  <= 1'b0;
  @(negedge clk_sys);
  while (!axil_rsp.awready) begin
    n++;
    if (n > AXI_WAIT) begin
      $display("AXI write address and data were never accepted");
      abort_run();
    end
    @(negedge clk_sys);
  end
  check_eq("wready", 32'(axil_rsp.wready), 32'd1);
  // Handshake lands on the next edge
  wr_cycle = cycle + 1;
  @(posedge clk_sys);
  axil_req.awvalid <= 1'b0;
  axil_req.wvalid  <= 1'b0;
  // Response must wait for bready
  repeat (bdelay) begin
    @(negedge clk_sys);
    check_eq("bvalid", 32'(axil_rsp.bvalid), 32'd1);
    @(posedge clk_sys);
  end
  axil_req.bready <= 1'b1;
  @(negedge clk_sys);
  check_eq("bvalid", 32'(axil_rsp.bvalid), 32'd1);
  resp = axil_rsp.bresp;
  @(posedge clk_sys);
  axil_req.bready <= 1'b0;
  @(negedge clk_sys);
  check_eq("bvalid", 32'(axil_rsp.bvalid), 32'd0);
endtask

task automatic axi_read(input logic [3:0] addr, input int rdelay,
                        output logic [31:0] data, output logic [1:0] resp);
  int n;
  n = 0;
  @(posedge clk_sys);
  axil_req.arvalid <= 1'b1;
  axil_req.araddr  <= addr;
  axil_req.rready  <= 1'b0;
  @(negedge clk_sys);
  while (!axil_rsp.arready) begin
    n++;
    if (n > AXI_WAIT) begin
      $display("AXI read address was never accepted");
      abort_run();
    end
    @(negedge clk_sys);
  end
  @(posedge clk_sys);
  axil_req.arvalid <= 1'b0;
  @(negedge clk_sys);
  check_eq("rvalid", 32'(axil_rsp.rvalid), 32'd1);
  data = axil_rsp.rdata;
  resp = axil_rsp.rresp;
  // Data frozen while rready is low
  repeat (rdelay) begin
    settle(1);
    check_eq("rvalid", 32'(axil_rsp.rvalid), 32'd1);
    check_eq("rdata", axil_rsp.rdata, data);
  end
  @(posedge clk_sys);
  axil_req.rready <= 1'b1;
  @(posedge clk_sys);
  axil_req.rready <= 1'b0;
  @(negedge clk_sys);
  check_eq("rvalid", 32'(axil_rsp.rvalid), 32'd0);
endtask

// Options, aspect outputs and aspect readback for one status word
task automatic check_decode(input logic [31:0] s);
  logic [12:0] arx;
  logic [12:0] ary;
  logic [31:0] rd;
  logic [1:0]  resp;
  if (s[2:1] == 2'd0) begin
    arx = s[3] ? 13'd3 : 13'd4;
    ary = s[3] ? 13'd4 : 13'd3;
  end else begin
    arx = {11'd0, s[2:1]} - 13'd1;
    ary = 13'd0;
  end
  check_eq("options", 32'(options), 32'(expect_options(s)));
  check_eq("video_arx", 32'(video_arx), 32'(arx));
  check_eq("video_ary", 32'(video_ary), 32'(ary));
  axi_read(REG_ASPECT, 0, rd, resp);
  check_eq("aspect rresp", 32'(resp), 32'(RESP_OKAY));
  check_eq("aspect rdata", rd, (32'(ary) << 16) | 32'(arx));
endtask

////////////////////
// Directed tests
////////////////////

task automatic test_reset();
  int rel;
  repeat (10) @(posedge clk_sys);
  RESET <= 1'b0;
  @(negedge clk_sys);
  rel = cycle;
  check_eq("rst_sys", 32'(rst_sys), 32'd1);
  check_release(1'b0, rel);
  check_release(1'b1, rel);
  check_players('0, '0);
  check_eq("pll_reset", 32'(pll_reset), 32'd0);
  check_eq("awready", 32'(axil_rsp.awready), 32'd0);
  check_eq("wready", 32'(axil_rsp.wready), 32'd0);
  check_eq("arready", 32'(axil_rsp.arready), 32'd0);
  check_eq("bvalid", 32'(axil_rsp.bvalid), 32'd0);
  check_eq("rvalid", 32'(axil_rsp.rvalid), 32'd0);
  // All layers and sprites on
  check_eq("options", 32'(options), 32'(expect_options(32'd0)));
  check_eq("video_arx", 32'(video_arx), 32'd4);
  check_eq("video_ary", 32'(video_ary), 32'd3);
endtask

task automatic test_keys();
  logic [12:0] ent;
  player_t     hit;
  player_t     e0;
  player_t     e1;
  int          i;
  for (i = 0; i < 21; i++) begin
    ent = KEY_MAP[i];
    hit = joy_to_player(11'(1) << ent[11:8]);
    e0 = ent[12] ? player_t'(0) : hit;
    e1 = ent[12] ? hit : player_t'(0);
    // One stage after the press nothing shows yet
    ps2_event(ent[7:0], 1'b1, 1'b1);
    settle(1);
    check_players('0, '0);
    settle(1);
    check_players(e0, e1);
    // Repeat without toggle flip is ignored
    ps2_event(ent[7:0], 1'b0, 1'b0);
    settle(2);
    check_players(e0, e1);
    ps2_event(ent[7:0], 1'b0, 1'b1);
    settle(2);
    check_players('0, '0);
  end
  for (i = 0; i < 4; i++) begin
    ps2_event(UNMAPPED[i], 1'b1, 1'b1);
    settle(2);
    check_players('0, '0);
  end
endtask

task automatic test_joysticks();
  logic [31:0] j0;
  logic [31:0] j1;
  logic [10:0] kb0;
  logic [10:0] kb1;
  logic [12:0] ent;
  int          i;
  for (i = 0; i < 20; i++) begin
    j0 = $random(seed);
    j1 = $random(seed);
    kb0 = '0;
    kb1 = '0;
    ent = KEY_MAP[(i * 9) % 21];
    // Every fourth pair also holds a key
    // Its joystick bit stays clear so only the key can set the field
    if (i % 4 == 3) begin
      if (ent[12]) begin
        kb1 = 11'(1) << ent[11:8];
        j1[ent[11:8]] = 1'b0;
      end else begin
        kb0 = 11'(1) << ent[11:8];
        j0[ent[11:8]] = 1'b0;
      end
      ps2_event(ent[7:0], 1'b1, 1'b1);
    end
    drive_joysticks(j0, j1);
    settle(2);
    check_players(joy_to_player(j0[10:0] | kb0), joy_to_player(j1[10:0] | kb1));
    if (i % 4 == 3) begin
      ps2_event(ent[7:0], 1'b0, 1'b1);
    end
  end
  drive_joysticks('0, '0);
  settle(2);
  check_players('0, '0);
endtask

task automatic test_status();
  logic [31:0] exp_status;
  logic [31:0] w;
  logic [31:0] rd;
  logic [31:0] j0;
  logic [31:0] j1;
  logic [3:0]  strb;
  logic [1:0]  resp;
  int          i;
  int          b;
  exp_status = '0;
  // Random words with full then partial byte enables
  for (i = 0; i < 8; i++) begin
    w = $random(seed);
    strb = (i < 3) ? 4'hF : 4'($random(seed));
    axi_write(REG_STATUS, w, strb, i % 3, resp);
    check_eq("bresp", 32'(resp), 32'(RESP_OKAY));
    for (b = 0; b < 4; b++) begin
      if (strb[b]) begin
        exp_status[8*b +: 8] = w[8*b +: 8];
      end
    end
    axi_read(REG_STATUS, (i + 1) % 3, rd, resp);
    check_eq("status rresp", 32'(resp), 32'(RESP_OKAY));
    check_eq("status rdata", rd, exp_status);
    check_decode(exp_status);
  end
  // Every aspect field with both orientations
  for (i = 0; i < 8; i++) begin
    w = $random(seed);
    w[3:0] = {3'(i), 1'b0};
    axi_write(REG_STATUS, w, 4'hF, 0, resp);
    check_decode(w);
  end
  // Player readback
  j0 = $random(seed);
  j1 = $random(seed);
  drive_joysticks(j0, j1);
  settle(2);
  // Joysticks move while the read response waits
  fork
    axi_read(REG_PLAYERS, 4, rd, resp);
    begin
      settle(1);
      drive_joysticks(~j0, ~j1);
    end
  join
  check_eq("players rresp", 32'(resp), 32'(RESP_OKAY));
  check_eq("players rdata", rd,
           {10'b0, joy_to_player(j1[10:0]), joy_to_player(j0[10:0])});
  drive_joysticks('0, '0);
  axi_write(REG_STATUS, 32'd0, 4'hF, 0, resp);
endtask

task automatic test_errors();
  logic [31:0] rd;
  logic [1:0]  resp;
  axi_write(4'hC, 32'hFFFF_FFFF, 4'hF, 1, resp);
  check_eq("bresp 0xC", 32'(resp), 32'(RESP_SLVERR));
  axi_write(REG_PLAYERS, 32'hFFFF_FFFF, 4'hF, 0, resp);
  check_eq("bresp 0x4", 32'(resp), 32'(RESP_SLVERR));
  // Nothing written by the bad writes
  axi_read(REG_STATUS, 0, rd, resp);
  check_eq("status rdata", rd, 32'd0);
  axi_read(4'hC, 1, rd, resp);
  check_eq("rresp 0xC", 32'(resp), 32'(RESP_SLVERR));
  check_eq("rdata 0xC", rd, 32'd0);
  // Soft reset through status bit 0
  check_eq("rst_core", 32'(rst_core), 32'd0);
  axi_write(REG_STATUS, 32'd1, 4'h1, 0, resp);
  check_eq("rst_core", 32'(rst_core), 32'd1);
  check_eq("rst_sys", 32'(rst_sys), 32'd0);
  settle(3);
  check_eq("rst_core", 32'(rst_core), 32'd1);
  axi_write(REG_STATUS, 32'd0, 4'h1, 0, resp);
  check_release(1'b1, wr_cycle);
  check_eq("rst_sys", 32'(rst_sys), 32'd0);
endtask

task automatic test_lock();
  int i;
  @(posedge clk_sys);
  pll_locked <= 1'b0;
  @(negedge clk_sys);
  // Reset rises at once
  // PLL reset waits for the edge
  check_eq("pll_reset", 32'(pll_reset), 32'd0);
  check_eq("rst_sys", 32'(rst_sys), 32'd1);
  for (i = 1; i <= 20; i++) begin
    @(posedge clk_sys);
    if (i == 5) begin
      pll_locked <= 1'b1;
    end
    @(negedge clk_sys);
    check_eq("pll_reset", 32'(pll_reset), 32'(i <= LOCK_HOLD));
    check_eq("rst_sys", 32'(rst_sys), 32'(i < 5 + RESET_STRETCH));
  end
endtask

`endif

//--- tests/tb_core_frontend.sv
////////////////////
// Testbench for the arcade core front end
// Clock, reset, DUT, timeout and the directed test sequence
////////////////////

`timescale 1ns/1ps

module tb_core_frontend
  import arcade_pkg::*;
;

  localparam int LOCK_HOLD     = 16;
  localparam int RESET_STRETCH = 4;
  // Whole sequence needs roughly 650 cycles, about 5x margin here
  localparam int MAX_CYCLES    = 3000;
  // Bound on any single AXI handshake wait
  localparam int AXI_WAIT      = 20;

  // Key map as {player 1, joystick bit, scan code}
  // Joystick bit order: right, left, down, up, buttons 1..4, start, coin, pause
  localparam logic [12:0] KEY_MAP [21] = '{
    {1'b0, 4'd0, 8'h74}, {1'b0, 4'd1, 8'h6B}, {1'b0, 4'd2, 8'h72},
    {1'b0, 4'd3, 8'h75}, {1'b0, 4'd4, 8'h14}, {1'b0, 4'd5, 8'h11},
    {1'b0, 4'd6, 8'h29}, {1'b0, 4'd7, 8'h12}, {1'b0, 4'd8, 8'h16},
    {1'b0, 4'd9, 8'h2E}, {1'b0, 4'd10, 8'h4D}, {1'b1, 4'd0, 8'h34},
    {1'b1, 4'd1, 8'h23}, {1'b1, 4'd2, 8'h2B}, {1'b1, 4'd3, 8'h2D},
    {1'b1, 4'd4, 8'h1C}, {1'b1, 4'd5, 8'h1B}, {1'b1, 4'd6, 8'h15},
    {1'b1, 4'd7, 8'h1D}, {1'b1, 4'd8, 8'h1E}, {1'b1, 4'd9, 8'h36}
  };

  // Codes with no mapping
  localparam logic [7:0] UNMAPPED [4] = '{8'h00, 8'h5A, 8'h76, 8'hF0};

  logic          clk_sys;
  logic          RESET;
  logic          pll_locked;
  ps2_event_t    ps2;
  logic [31:0]   joystick_0;
  logic [31:0]   joystick_1;
  axil_req_t     axil_req;
  logic          pll_reset;
  logic          rst_sys;
  logic          rst_core;
  player_t       player_0;
  player_t       player_1;
  game_options_t options;
  logic [12:0]   video_arx;
  logic [12:0]   video_ary;
  axil_rsp_t     axil_rsp;

  // Bookkeeping
  int   cycle = 0;
  int   wr_cycle;
  int   seed = 25;
  logic tgl;

  core_frontend #(
    .LOCK_HOLD    (LOCK_HOLD),
    .RESET_STRETCH(RESET_STRETCH)
  ) dut (
    .clk_sys   (clk_sys),
    .RESET     (RESET),
    .pll_locked(pll_locked),
    .ps2       (ps2),
    .joystick_0(joystick_0),
    .joystick_1(joystick_1),
    .axil_req  (axil_req),
    .pll_reset (pll_reset),
    .rst_sys   (rst_sys),
    .rst_core  (rst_core),
    .player_0  (player_0),
    .player_1  (player_1),
    .options   (options),
    .video_arx (video_arx),
    .video_ary (video_ary),
    .axil_rsp  (axil_rsp)
  );

  ////////////////////
  // Reference models
  ////////////////////

  // Raw joystick bits to player fields
  function automatic player_t joy_to_player(input logic [10:0] j);
    player_t p;
    p.right   = j[0];
    p.left    = j[1];
    p.down    = j[2];
    p.up      = j[3];
    p.buttons = j[7:4];
    p.start   = j[8];
    p.coin    = j[9];
    p.pause   = j[10];
    return p;
  endfunction

  // Option fields from a status word
  function automatic game_options_t expect_options(input logic [31:0] s);
    game_options_t o;
    o.offset_x       = s[27:24];
    o.offset_y       = s[31:28];
    o.rotate         = s[3];
    o.flip           = s[4];
    o.compatibility  = s[8];
    o.service        = s[9];
    // Enables are inverted menu bits
    o.sprite_en      = ~s[10];
    o.layer_en[0]    = ~s[11];
    o.layer_en[1]    = ~s[12];
    o.layer_en[2]    = ~s[13];
    o.game_index     = s[21:18];
    o.scandoubler_fx = s[7:5];
    return o;
  endfunction

  `include "tb_tasks.svh"

  initial clk_sys = 1'b0;
  always #5 clk_sys = ~clk_sys;

  // Run limit
  always @(posedge clk_sys) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout: simulation ran past %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  initial begin
    RESET      <= 1'b1;
    pll_locked <= 1'b1;
    ps2        <= '0;
    joystick_0 <= '0;
    joystick_1 <= '0;
    axil_req   <= '0;
    tgl = 1'b0;
    test_reset();
    test_keys();
    test_joysticks();
    test_status();
    test_errors();
    test_lock();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- build.f
+incdir+tests
common/arcade_pkg.sv
logic/reset_ctrl.sv
logic/lock_monitor.sv
input/key_decoder.sv
input/player_merge.sv
logic/status_regs.sv
logic/core_frontend.sv
tests/tb_core_frontend.sv

//--- run.sh
#!/bin/sh
# Build and run the core front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
  --top-module tb_core_frontend -o tb_core_frontend
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_core_frontend)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with an error"
  exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
